// ==== rtl/decode_front_pkg.sv ====
`default_nettype none

package decode_front_pkg;

    // ------------------------------------------------
    // sizes and constants.
    // ------------------------------------------------
    localparam int pair_depth = 4;
    localparam int iq_depth   = 4;
    localparam int uop_width  = 4;
    localparam int pair_ptr_w = $clog2(pair_depth);
    localparam int iq_ptr_w   = $clog2(iq_depth);

    // addi.w r0,r0,0.
    localparam logic [31:0] inst_nop = 32'h0280_0000;

    // ------------------------------------------------
    // decode types.
    // ------------------------------------------------
    typedef enum logic [3:0] {
        op_add_w, op_sub_w, op_addi_w, op_lu12i_w, op_ld_w, op_st_w,
        op_beq, op_csrrd, op_syscall, op_break, op_unknown
    } major_op_t;

    typedef enum logic [uop_width-1:0] {
        uop_nop, uop_add, uop_sub, uop_lui, uop_load, uop_store,
        uop_branch, uop_csr, uop_syscall, uop_break, uop_ine
    } uop_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        uop_t        uop;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        is_alu;
        logic        is_syscall;
        logic        is_break;
        logic        is_priv;
        logic        valid;
    } decoded_slot_t;

endpackage

`default_nettype wire

// ==== rtl/decode_slot_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decode_slot_if;
    import decode_front_pkg::*;

    logic [31:0] inst;
    logic [31:0] pc;
    logic        valid;
    uop_t        uop;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic        is_alu;
    logic        is_syscall;
    logic        is_break;
    logic        is_priv;

    modport src (output inst, pc, valid);
    modport dec (input inst, valid,
                 output uop, imm, rd, rj, rk, is_alu, is_syscall, is_break, is_priv);
    modport sink (input inst, pc, valid, uop, imm, rd, rj, rk,
                  is_alu, is_syscall, is_break, is_priv);
endinterface

`default_nettype wire

// ==== rtl/inst_pair_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_pair_buffer (
    input  logic        aclk,
    input  logic        reset,
    input  logic        flush,
    input  logic        fetch_valid,
    input  logic        fetch_pair,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] fetch_inst0,
    input  logic [31:0] fetch_inst1,
    output logic        fetch_allowin,
    decode_slot_if.src  slot [2],
    output logic        pair_readygo,
    input  logic        id_allowin
);
    import decode_front_pkg::*;

    logic [31:0] pc_mem    [pair_depth];
    logic [31:0] inst0_mem [pair_depth];
    logic [31:0] inst1_mem [pair_depth];
    logic        pair_mem  [pair_depth];

    logic [pair_ptr_w-1:0] wr_ptr;
    logic [pair_ptr_w-1:0] rd_ptr;
    logic [pair_ptr_w:0]   count;
    logic                  push;
    logic                  pop;
    logic                  head_pair;

    // no new pair is taken on a flush edge since it would be dropped anyway.
    assign fetch_allowin = !flush && (count != (pair_ptr_w + 1)'(pair_depth));
    assign pair_readygo  = (count != '0);
    assign push          = fetch_valid && fetch_allowin;
    assign pop           = pair_readygo && id_allowin;

    // ------------------------------------------------
    // pointers and occupancy.
    // ------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= fetch_pc;
            inst0_mem[wr_ptr] <= fetch_inst0;
            inst1_mem[wr_ptr] <= fetch_inst1;
            pair_mem[wr_ptr]  <= fetch_pair;
        end
    end

    // ------------------------------------------------
    // head pair to the decoders.
    // ------------------------------------------------
    assign head_pair = pair_readygo && pair_mem[rd_ptr];

    assign slot[0].valid = pair_readygo;
    assign slot[0].pc    = pc_mem[rd_ptr];
    assign slot[0].inst  = pair_readygo ? inst0_mem[rd_ptr] : inst_nop;

    // second slot sits one word after the first.
    assign slot[1].valid = head_pair;
    assign slot[1].pc    = pc_mem[rd_ptr] + 32'd4;
    assign slot[1].inst  = head_pair ? inst1_mem[rd_ptr] : inst_nop;

endmodule

`default_nettype wire

// ==== rtl/slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_decoder (
    decode_slot_if.dec slot
);
    import decode_front_pkg::*;

    logic [31:0] inst;
    major_op_t   op;

    assign inst = slot.inst;

    // ------------------------------------------------
    // opcode classification.
    // ------------------------------------------------
    always_comb begin
        if (inst[31:15] == 17'h00020)
            op = op_add_w;
        else if (inst[31:15] == 17'h00022)
            op = op_sub_w;
        else if (inst[31:22] == 10'h00a)
            op = op_addi_w;
        else if (inst[31:25] == 7'h0a)
            op = op_lu12i_w;
        else if (inst[31:22] == 10'h0a2)
            op = op_ld_w;
        else if (inst[31:22] == 10'h0a6)
            op = op_st_w;
        else if (inst[31:26] == 6'h16)
            op = op_beq;
        else if (inst[31:24] == 8'h04 && inst[9:5] == 5'd0)
            op = op_csrrd;    // rj of zero selects csrrd.
        else if (inst[31:15] == 17'h00056)
            op = op_syscall;
        else if (inst[31:15] == 17'h00054)
            op = op_break;
        else
            op = op_unknown;
    end

    assign slot.rd = inst[4:0];
    assign slot.rj = inst[9:5];
    assign slot.rk = inst[14:10];

    // ------------------------------------------------
    // micro-op, immediate and class flags.
    // ------------------------------------------------
    always_comb begin
        slot.uop        = uop_ine;
        slot.imm        = '0;
        slot.is_alu     = 1'b0;
        slot.is_syscall = 1'b0;
        slot.is_break   = 1'b0;
        slot.is_priv    = 1'b0;
        if (!slot.valid) begin
            // an empty slot behaves like a nop.
            slot.uop    = uop_nop;
            slot.is_alu = 1'b1;
        end else begin
            case (op)
                op_add_w: begin
                    slot.uop    = uop_add;
                    slot.is_alu = 1'b1;
                end
                op_sub_w: begin
                    slot.uop    = uop_sub;
                    slot.is_alu = 1'b1;
                end
                op_addi_w: begin
                    slot.uop    = uop_add;
                    slot.imm    = {{20{inst[21]}}, inst[21:10]};
                    slot.is_alu = 1'b1;
                end
                op_lu12i_w: begin
                    slot.uop    = uop_lui;
                    slot.imm    = {inst[24:5], 12'b0};
                    slot.is_alu = 1'b1;
                end
                op_ld_w: begin
                    slot.uop = uop_load;
                    slot.imm = {{20{inst[21]}}, inst[21:10]};
                end
                op_st_w: begin
                    slot.uop = uop_store;
                    slot.imm = {{20{inst[21]}}, inst[21:10]};
                end
                op_beq: begin
                    slot.uop = uop_branch;
                    slot.imm = {{14{inst[25]}}, inst[25:10], 2'b00};
                end
                op_csrrd: begin
                    slot.uop     = uop_csr;
                    slot.imm     = {18'b0, inst[23:10]};
                    slot.is_priv = 1'b1;
                end
                op_syscall: begin
                    slot.uop        = uop_syscall;
                    slot.imm        = {17'b0, inst[14:0]};
                    slot.is_syscall = 1'b1;
                end
                op_break: begin
                    slot.uop      = uop_break;
                    slot.imm      = {17'b0, inst[14:0]};
                    slot.is_break = 1'b1;
                end
                default: slot.uop = uop_ine;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/id_issue_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_issue_reg (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic                           flush,
    decode_slot_if.sink                    slot [2],
    input  logic                           pair_readygo,
    output logic                           id_allowin,
    output logic                           reg_readygo,
    input  logic                           iq_allowin,
    output decode_front_pkg::decoded_slot_t reg_slot [2]
);
    import decode_front_pkg::*;

    decoded_slot_t dec_slot [2];
    logic          reg_valid;
    logic          load;

    // an empty register carries nops that look like alu ops.
    function automatic decoded_slot_t bubble_slot();
        decoded_slot_t b;
        b        = '0;
        b.inst   = inst_nop;
        b.uop    = uop_nop;
        b.is_alu = 1'b1;
        return b;
    endfunction

    for (genvar g = 0; g < 2; g++) begin : g_pack
        assign dec_slot[g] = '{pc: slot[g].pc, inst: slot[g].inst, uop: slot[g].uop,
                               imm: slot[g].imm, rd: slot[g].rd, rj: slot[g].rj,
                               rk: slot[g].rk, is_alu: slot[g].is_alu,
                               is_syscall: slot[g].is_syscall,
                               is_break: slot[g].is_break, is_priv: slot[g].is_priv,
                               valid: slot[g].valid};
    end

    assign reg_readygo = reg_valid;
    assign id_allowin  = !reg_valid || iq_allowin;
    assign load        = pair_readygo && id_allowin;

    // ------------------------------------------------
    // load, hold or drain to a bubble.
    // ------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            reg_valid <= 1'b0;
            for (int i = 0; i < 2; i++)
                reg_slot[i] <= bubble_slot();
        end else if (load) begin
            reg_valid <= 1'b1;
            for (int i = 0; i < 2; i++)
                reg_slot[i] <= dec_slot[i];
        end else if (iq_allowin) begin
            // pair left for the queue with nothing behind it.
            reg_valid <= 1'b0;
            for (int i = 0; i < 2; i++)
                reg_slot[i] <= bubble_slot();
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            flush,
    input  decode_front_pkg::decoded_slot_t reg_slot [2],
    input  logic                            reg_readygo,
    output logic                            iq_allowin,
    output decode_front_pkg::decoded_slot_t issue_slot [2],
    output logic                            issue_valid,
    input  logic                            issue_ready
);
    import decode_front_pkg::*;

    decoded_slot_t mem [iq_depth][2];

    logic [iq_ptr_w-1:0] wr_ptr;
    logic [iq_ptr_w-1:0] rd_ptr;
    logic [iq_ptr_w:0]   count;
    logic                push;
    logic                pop;

    assign iq_allowin  = (count != (iq_ptr_w + 1)'(iq_depth));
    assign issue_valid = (count != '0);
    assign push        = reg_readygo && iq_allowin;
    assign pop         = issue_valid && issue_ready;

    // ------------------------------------------------
    // pointers and occupancy.
    // ------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pair storage.
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr][0] <= reg_slot[0];
            mem[wr_ptr][1] <= reg_slot[1];
        end
    end

    // head pair stays put until issue takes it.
    always_comb begin
        for (int i = 0; i < 2; i++)
            issue_slot[i] = mem[rd_ptr][i];
    end

endmodule

`default_nettype wire

// ==== rtl/decode_front_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_front_top (
    input  logic                         aclk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         fetch_valid,
    input  logic [31:0]                  fetch_pc,
    input  logic [31:0]                  fetch_inst0,
    input  logic [31:0]                  fetch_inst1,
    input  logic                         fetch_pair,
    output logic                         fetch_allowin,
    output logic                         issue_valid,
    output logic [1:0][31:0]             issue_pc,
    output logic [1:0][31:0]             issue_inst,
    output decode_front_pkg::uop_t [1:0] issue_uop,
    output logic [1:0][31:0]             issue_imm,
    output logic [1:0][4:0]              issue_rd,
    output logic [1:0][4:0]              issue_rj,
    output logic [1:0][4:0]              issue_rk,
    output logic [1:0]                   issue_is_alu,
    output logic [1:0]                   issue_is_syscall,
    output logic [1:0]                   issue_is_break,
    output logic [1:0]                   issue_is_priv,
    output logic [1:0]                   issue_slot_valid,
    input  logic                         issue_ready
);
    import decode_front_pkg::*;

    decoded_slot_t reg_slot   [2];
    decoded_slot_t issue_slot [2];
    logic          pair_readygo;
    logic          id_allowin;
    logic          reg_readygo;
    logic          iq_allowin;

    decode_slot_if slot_bus [2] ();

    // ------------------------------------------------
    // buffer, decoders, register, queue.
    // ------------------------------------------------
    inst_pair_buffer u_buffer (
        .aclk(aclk), .reset(reset), .flush(flush),
        .fetch_valid(fetch_valid), .fetch_pair(fetch_pair), .fetch_pc(fetch_pc),
        .fetch_inst0(fetch_inst0), .fetch_inst1(fetch_inst1),
        .fetch_allowin(fetch_allowin), .slot(slot_bus),
        .pair_readygo(pair_readygo), .id_allowin(id_allowin)
    );

    for (genvar g = 0; g < 2; g++) begin : g_dec
        slot_decoder u_dec (.slot(slot_bus[g]));
    end

    id_issue_reg u_id_reg (
        .aclk(aclk), .reset(reset), .flush(flush), .slot(slot_bus),
        .pair_readygo(pair_readygo), .id_allowin(id_allowin),
        .reg_readygo(reg_readygo), .iq_allowin(iq_allowin), .reg_slot(reg_slot)
    );

    issue_queue u_iq (
        .aclk(aclk), .reset(reset), .flush(flush), .reg_slot(reg_slot),
        .reg_readygo(reg_readygo), .iq_allowin(iq_allowin), .issue_slot(issue_slot),
        .issue_valid(issue_valid), .issue_ready(issue_ready)
    );

    // flatten the head pair for issue.
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            issue_pc[i]         = issue_slot[i].pc;
            issue_inst[i]       = issue_slot[i].inst;
            issue_uop[i]        = issue_slot[i].uop;
            issue_imm[i]        = issue_slot[i].imm;
            issue_rd[i]         = issue_slot[i].rd;
            issue_rj[i]         = issue_slot[i].rj;
            issue_rk[i]         = issue_slot[i].rk;
            issue_is_alu[i]     = issue_slot[i].is_alu;
            issue_is_syscall[i] = issue_slot[i].is_syscall;
            issue_is_break[i]   = issue_slot[i].is_break;
            issue_is_priv[i]    = issue_slot[i].is_priv;
            issue_slot_valid[i] = issue_slot[i].valid;
        end
    end

endmodule

`default_nettype wire

// ==== test/decode_front_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_front_sva (
    input logic                         aclk,
    input logic                         reset,
    input logic                         flush,
    input logic                         fetch_allowin,
    input logic                         issue_valid,
    input logic                         issue_ready,
    input logic [1:0][31:0]             issue_pc,
    input logic [1:0][31:0]             issue_inst,
    input decode_front_pkg::uop_t [1:0] issue_uop,
    input logic [1:0][31:0]             issue_imm,
    input logic [1:0]                   issue_slot_valid
);
    import decode_front_pkg::*;

    int error_count = 0;

    // head pair holds while issue stalls.
    a_hold_stalled: assert property (@(posedge aclk) disable iff (reset)
        issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue_pc)
            && $stable(issue_inst) && $stable(issue_uop) && $stable(issue_imm))
    else begin
        error_count++;
        $error("issue outputs changed while issue was stalled");
    end

    a_flush_empties: assert property (@(posedge aclk) disable iff (reset)
        flush |=> !issue_valid)
    else begin
        error_count++;
        $error("issue_valid still high on the edge after a flush");
    end

    a_reset_state: assert property (@(posedge aclk)
        reset |=> !issue_valid && fetch_allowin)
    else begin
        error_count++;
        $error("wrong issue_valid or fetch_allowin after reset");
    end

    // slot 1 is always the next word.
    a_slot1_pc: assert property (@(posedge aclk) disable iff (reset)
        issue_valid |-> issue_pc[1] == issue_pc[0] + 32'd4)
    else begin
        error_count++;
        $error("slot 1 pc is not slot 0 pc plus 4");
    end

    a_lone_slot_nop: assert property (@(posedge aclk) disable iff (reset)
        issue_valid && !issue_slot_valid[1] |-> issue_uop[1] == uop_nop)
    else begin
        error_count++;
        $error("empty slot 1 does not carry a nop");
    end

endmodule

bind decode_front_top decode_front_sva u_sva (
    .aclk(aclk), .reset(reset), .flush(flush), .fetch_allowin(fetch_allowin),
    .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_pc(issue_pc),
    .issue_inst(issue_inst), .issue_uop(issue_uop), .issue_imm(issue_imm),
    .issue_slot_valid(issue_slot_valid)
);

`default_nettype wire

// ==== test/decode_front_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_front_tb;
    import decode_front_pkg::*;

    logic             aclk;
    logic             reset;
    logic             flush;
    logic             fetch_valid;
    logic [31:0]      fetch_pc;
    logic [31:0]      fetch_inst0;
    logic [31:0]      fetch_inst1;
    logic             fetch_pair;
    logic             fetch_allowin;
    logic             issue_valid;
    logic [1:0][31:0] issue_pc;
    logic [1:0][31:0] issue_inst;
    uop_t [1:0]       issue_uop;
    logic [1:0][31:0] issue_imm;
    logic [1:0][4:0]  issue_rd;
    logic [1:0][4:0]  issue_rj;
    logic [1:0][4:0]  issue_rk;
    logic [1:0]       issue_is_alu;
    logic [1:0]       issue_is_syscall;
    logic [1:0]       issue_is_break;
    logic [1:0]       issue_is_priv;
    logic [1:0]       issue_slot_valid;
    logic             issue_ready;

    logic [31:0]   rng_state = 32'd6417;
    major_op_t     kind0;
    major_op_t     kind1;
    decoded_slot_t exp0_q [$];
    decoded_slot_t exp1_q [$];

    decode_front_top uut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic major_op_t random_kind();
        return major_op_t'(next_rand() % 11);
    endfunction

    // builds a word of the given group around random fields.
    function automatic logic [31:0] make_inst(major_op_t k, logic [31:0] r);
        case (k)
            op_add_w:   return {17'h00020, r[14:0]};
            op_sub_w:   return {17'h00022, r[14:0]};
            op_addi_w:  return {10'h00a, r[21:0]};
            op_lu12i_w: return {7'h0a, r[24:0]};
            op_ld_w:    return {10'h0a2, r[21:0]};
            op_st_w:    return {10'h0a6, r[21:0]};
            op_beq:     return {6'h16, r[25:0]};
            op_csrrd:   return {8'h04, r[23:10], 5'd0, r[4:0]};
            op_syscall: return {17'h00056, r[14:0]};
            op_break:   return {17'h00054, r[14:0]};
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    // ------------------------------------------------
    // reference decode and scoreboard.
    // ------------------------------------------------
    function automatic decoded_slot_t ref_decode(major_op_t k, logic [31:0] inst, logic v,
                                                 logic [31:0] pc);
        decoded_slot_t d;
        d       = '0;
        d.pc    = pc;
        d.valid = v;
        d.inst  = inst_nop;
        d.uop   = uop_nop;
        if (!v) begin
            d.is_alu = 1'b1;
            return d;
        end
        d.inst = inst;
        d.rd   = inst[4:0];
        d.rj   = inst[9:5];
        d.rk   = inst[14:10];
        case (k)
            op_add_w, op_addi_w: d.uop = uop_add;
            op_sub_w:            d.uop = uop_sub;
            op_lu12i_w:          d.uop = uop_lui;
            op_ld_w:             d.uop = uop_load;
            op_st_w:             d.uop = uop_store;
            op_beq:              d.uop = uop_branch;
            op_csrrd:            d.uop = uop_csr;
            op_syscall:          d.uop = uop_syscall;
            op_break:            d.uop = uop_break;
            default:             d.uop = uop_ine;
        endcase
        case (k)
            op_addi_w, op_ld_w, op_st_w: d.imm = 32'($signed(inst[21:10]));
            op_lu12i_w:                  d.imm = {inst[24:5], 12'h000};
            op_beq:                      d.imm = 32'($signed(inst[25:10])) << 2;
            op_csrrd:                    d.imm = {18'b0, inst[23:10]};
            op_syscall, op_break:        d.imm = {17'b0, inst[14:0]};
            default:                     d.imm = '0;
        endcase
        d.is_alu     = k inside {op_add_w, op_sub_w, op_addi_w, op_lu12i_w};
        d.is_syscall = (k == op_syscall);
        d.is_break   = (k == op_break);
        d.is_priv    = (k == op_csrrd);
        return d;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_slot(input int s, input decoded_slot_t e);
        assert (issue_pc[s] === e.pc && issue_inst[s] === e.inst && issue_uop[s] === e.uop
                && issue_imm[s] === e.imm && issue_rd[s] === e.rd && issue_rj[s] === e.rj
                && issue_rk[s] === e.rk && issue_is_alu[s] === e.is_alu
                && issue_is_syscall[s] === e.is_syscall && issue_is_break[s] === e.is_break
                && issue_is_priv[s] === e.is_priv && issue_slot_valid[s] === e.valid)
        else stop_on_error($sformatf("FAIL %0d ns: slot %0d pc %h inst %h uop %s imm %h, %s",
                                     $time, s, issue_pc[s], issue_inst[s],
                                     issue_uop[s].name(), issue_imm[s],
                                     $sformatf("expected pc %h inst %h uop %s imm %h",
                                               e.pc, e.inst, e.uop.name(), e.imm)));
    endtask

    always @(posedge aclk) begin
        if (!reset && flush) begin
            exp0_q.delete();
            exp1_q.delete();
        end else if (!reset) begin
            if (issue_valid && issue_ready) begin
                assert (exp0_q.size() != 0)
                else stop_on_error($sformatf("FAIL %0d ns: pair issued, none pending", $time));
                check_slot(0, exp0_q.pop_front());
                check_slot(1, exp1_q.pop_front());
            end
            if (fetch_valid && fetch_allowin) begin
                exp0_q.push_back(ref_decode(kind0, fetch_inst0, 1'b1, fetch_pc));
                exp1_q.push_back(ref_decode(kind1, fetch_inst1, fetch_pair, fetch_pc + 32'd4));
            end
        end
    end

    always @(negedge aclk) begin
        assert (uut.u_sva.error_count == 0)
        else stop_on_error("an assertion in the bound checker failed");
    end

    // ------------------------------------------------
    // stimulus.
    // ------------------------------------------------
    task automatic drive(input logic fv, input major_op_t k0, input major_op_t k1,
                         input logic pair, input logic rdy);
        logic [31:0] r;
        @(posedge aclk);
        #2;
        r           = next_rand();
        kind0       = k0;
        kind1       = k1;
        fetch_valid = fv;
        fetch_pc    = {r[31:2], 2'b00};
        fetch_inst0 = make_inst(k0, next_rand());
        fetch_inst1 = make_inst(k1, next_rand());
        fetch_pair  = pair;
        issue_ready = rdy;
    endtask

    task automatic wait_drained();
        int t;
        for (t = 0; t < 200; t++) begin
            @(posedge aclk);
            #2;
            if (exp0_q.size() == 0 && !issue_valid)
                break;
        end
        assert (t < 200) else stop_on_error("timeout while waiting for the pipeline to drain");
    endtask

    initial begin
        int t;
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst0 = inst_nop;
        fetch_inst1 = inst_nop;
        fetch_pair  = 1'b0;
        issue_ready = 1'b0;
        kind0       = op_addi_w;
        kind1       = op_addi_w;
        repeat (16) @(posedge aclk);
        #2;
        reset = 1'b0;

        // every group in both slots, then a lone slot 0.
        for (int k = 0; k < 11; k++)
            drive(1'b1, major_op_t'(k), major_op_t'((k + 1) % 11), 1'b1, 1'b1);
        drive(1'b1, op_lu12i_w, op_break, 1'b0, 1'b1);
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b1);
        wait_drained();

        repeat (300)
            drive(next_rand() % 4 != 0, random_kind(), random_kind(), next_rand() % 4 != 0,
                  next_rand() % 2 != 0);
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b1);
        wait_drained();

        // issue stalled until fetch sees back-pressure.
        for (t = 0; t < 40; t++) begin
            drive(1'b1, random_kind(), random_kind(), 1'b1, 1'b0);
            if (!fetch_allowin)
                break;
        end
        assert (t < 40) else stop_on_error("timeout while waiting for fetch_allowin to drop");
        assert (exp0_q.size() == 9)
        else stop_on_error($sformatf("FAIL %0d ns: %0d pairs in flight at stall, expected 9",
                                     $time, exp0_q.size()));
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b1);
        wait_drained();

        repeat (5)
            drive(1'b1, random_kind(), random_kind(), 1'b1, 1'b0);
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b0);
        flush = 1'b1;
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b0);
        flush = 1'b0;
        drive(1'b1, op_st_w, op_csrrd, 1'b1, 1'b1);
        drive(1'b0, op_add_w, op_add_w, 1'b0, 1'b1);
        wait_drained();

        if (uut.u_sva.error_count != 0) begin
            stop_on_error("an assertion in the bound checker failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== decode_front.f ====
rtl/decode_front_pkg.sv
rtl/decode_slot_if.sv
rtl/inst_pair_buffer.sv
rtl/slot_decoder.sv
rtl/id_issue_reg.sv
rtl/issue_queue.sv
rtl/decode_front_top.sv
test/decode_front_sva.sv
test/decode_front_tb.sv
